// ==== i3c_ccc_pkg.sv ====
// I3C CCC shared definitions

package i3c_ccc_pkg;

  // One byte on the I3C bus
  typedef logic [7:0] ccc_byte_t;

  // Queue size register, TX RX IBI CR from the top byte down
  typedef logic [31:0] queue_size_t;

  // Broadcast codes
  localparam ccc_byte_t CCC_BCAST_ENTHDR0 = 8'h20;
  localparam ccc_byte_t CCC_BCAST_RSTACT  = 8'h2A;

  // Direct codes
  localparam ccc_byte_t CCC_DIRECT_RSTACT = 8'h9A;
  localparam ccc_byte_t CCC_DIRECT_GETMWL = 8'h8B;
  localparam ccc_byte_t CCC_DIRECT_GETMRL = 8'h8C;

  // RSTACT defining bytes
  localparam ccc_byte_t RSTACT_NO_RESET         = 8'h00;
  localparam ccc_byte_t RSTACT_PERIPHERAL_RESET = 8'h01;

  // Bits shifted out per response
  localparam int unsigned RESP_BITS = 8;

  // Remaining-bit counter, holds 0 to RESP_BITS
  typedef logic [$clog2(RESP_BITS + 1)-1:0] resp_cnt_t;

  // Position of each byte inside a CCC frame
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_CODE    = 2'd1,
    ST_DEFBYTE = 2'd2,
    ST_DATA    = 2'd3
  } frame_state_e;

endpackage

// ==== ccc_frame_ctrl.sv ====
// CCC frame sequencer
`timescale 1ns/1ps

module ccc_frame_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  i3c_ccc_pkg::ccc_byte_t rx_byte_i,
  input  logic                   rx_byte_valid_i,
  input  logic                   frame_start_i,
  input  logic                   frame_stop_i,

  output logic                   code_valid_o,
  output logic                   defbyte_valid_o,
  output logic                   data_valid_o
);

  i3c_ccc_pkg::frame_state_e state_q;
  i3c_ccc_pkg::frame_state_e state_d;

  logic byte_accept;
  logic code_has_defbyte;

  // Start and stop win over a byte in the same cycle
  assign byte_accept = rx_byte_valid_i && !frame_start_i && !frame_stop_i;

  // Strobes follow the byte in the same cycle
  assign code_valid_o    = byte_accept && (state_q == i3c_ccc_pkg::ST_CODE);
  assign defbyte_valid_o = byte_accept && (state_q == i3c_ccc_pkg::ST_DEFBYTE);
  assign data_valid_o    = byte_accept && (state_q == i3c_ccc_pkg::ST_DATA);

  // Only RSTACT carries a defining byte here
  always_comb begin
    case (rx_byte_i)
      i3c_ccc_pkg::CCC_BCAST_RSTACT,
      i3c_ccc_pkg::CCC_DIRECT_RSTACT: begin
        code_has_defbyte = 1'b1;
      end
      default: begin
        code_has_defbyte = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    if (frame_stop_i) begin
      state_d = i3c_ccc_pkg::ST_IDLE;
    end else if (frame_start_i) begin
      state_d = i3c_ccc_pkg::ST_CODE;
    end else if (rx_byte_valid_i) begin
      case (state_q)
        i3c_ccc_pkg::ST_CODE: begin
          if (code_has_defbyte) begin
            state_d = i3c_ccc_pkg::ST_DEFBYTE;
          end else begin
            state_d = i3c_ccc_pkg::ST_DATA;
          end
        end
        i3c_ccc_pkg::ST_DEFBYTE: begin
          state_d = i3c_ccc_pkg::ST_DATA;
        end
        // Idle bytes are dropped, data stays data
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_ccc_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== ccc.sv ====
// CCC field latch and decoder
`timescale 1ns/1ps

module ccc (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  i3c_ccc_pkg::ccc_byte_t   rx_byte_i,
  input  logic                     code_valid_i,
  input  logic                     defbyte_valid_i,
  input  logic                     data_valid_i,

  input  i3c_ccc_pkg::queue_size_t queue_size_i,

  output i3c_ccc_pkg::ccc_byte_t   resp_byte_o,
  output logic                     resp_load_o,

  output logic                     is_in_hdr_mode_o,

  output i3c_ccc_pkg::ccc_byte_t   rst_action_o,
  output logic                     rst_action_valid_o
);

  i3c_ccc_pkg::ccc_byte_t code_q;
  i3c_ccc_pkg::ccc_byte_t defbyte_q;
  i3c_ccc_pkg::ccc_byte_t data_q;
  logic                   code_valid_q;
  logic                   defbyte_valid_q;

  i3c_ccc_pkg::ccc_byte_t tx_buf_size;
  i3c_ccc_pkg::ccc_byte_t rx_buf_size;
  logic                   is_getmxl;
  logic                   is_rstact;

  // Code 0x00 after reset decodes to nothing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q          <= '0;
      code_valid_q    <= 1'b0;
      defbyte_valid_q <= 1'b0;
    end else begin
      if (code_valid_i) begin
        code_q <= rx_byte_i;
      end
      code_valid_q    <= code_valid_i;
      defbyte_valid_q <= defbyte_valid_i;
    end
  end

  // Payload bytes
  always_ff @(posedge clk_i) begin
    if (defbyte_valid_i) begin
      defbyte_q <= rx_byte_i;
    end
    // Kept for SETMWL/SETMRL, not decoded yet
    if (data_valid_i) begin
      data_q <= rx_byte_i;
    end
  end

  assign tx_buf_size = queue_size_i[31:24];
  assign rx_buf_size = queue_size_i[23:16];

  always_comb begin
    resp_byte_o = '0;
    is_getmxl   = 1'b0;
    is_rstact   = 1'b0;
    case (code_q)
      i3c_ccc_pkg::CCC_DIRECT_GETMRL: begin
        resp_byte_o = rx_buf_size;
        is_getmxl   = 1'b1;
      end
      i3c_ccc_pkg::CCC_DIRECT_GETMWL: begin
        resp_byte_o = tx_buf_size;
        is_getmxl   = 1'b1;
      end
      i3c_ccc_pkg::CCC_BCAST_RSTACT,
      i3c_ccc_pkg::CCC_DIRECT_RSTACT: begin
        is_rstact = 1'b1;
      end
      default: ;
    endcase
  end

  // One load per code byte, not per cycle the code is held
  assign resp_load_o = code_valid_q && is_getmxl;

  // Level until another code is latched
  assign is_in_hdr_mode_o = (code_q == i3c_ccc_pkg::CCC_BCAST_ENTHDR0);

  always_comb begin
    rst_action_o       = '0;
    rst_action_valid_o = 1'b0;
    if (defbyte_valid_q && is_rstact) begin
      case (defbyte_q)
        i3c_ccc_pkg::RSTACT_NO_RESET,
        i3c_ccc_pkg::RSTACT_PERIPHERAL_RESET: begin
          rst_action_o       = defbyte_q;
          rst_action_valid_o = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== ccc_resp_shifter.sv ====
// CCC response serializer
`timescale 1ns/1ps

module ccc_resp_shifter (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  i3c_ccc_pkg::ccc_byte_t resp_byte_i,
  input  logic                   resp_load_i,
  input  logic                   tx_bit_req_i,

  output logic                   tx_bit_o,
  output logic                   tx_active_o
);

  i3c_ccc_pkg::ccc_byte_t shift_q;
  i3c_ccc_pkg::resp_cnt_t bits_left_q;

  // Bits still to go, zero means idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bits_left_q <= '0;
    end else if (resp_load_i) begin
      bits_left_q <= i3c_ccc_pkg::resp_cnt_t'(i3c_ccc_pkg::RESP_BITS);
    end else if (tx_bit_req_i && tx_active_o) begin
      bits_left_q <= bits_left_q - 1'b1;
    end
  end

  // Load beats shift, a new response restarts from its MSB
  always_ff @(posedge clk_i) begin
    if (resp_load_i) begin
      shift_q <= resp_byte_i;
    end else if (tx_bit_req_i && tx_active_o) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign tx_active_o = (bits_left_q != '0);

  assign tx_bit_o = tx_active_o & shift_q[7];

endmodule

// ==== ccc_top.sv ====
// CCC front end top level
`timescale 1ns/1ps

module ccc_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  i3c_ccc_pkg::ccc_byte_t   rx_byte_i,
  input  logic                     rx_byte_valid_i,
  input  logic                     frame_start_i,
  input  logic                     frame_stop_i,

  input  i3c_ccc_pkg::queue_size_t queue_size_i,
  input  logic                     tx_bit_req_i,

  output logic                     is_in_hdr_mode_o,
  output i3c_ccc_pkg::ccc_byte_t   rst_action_o,
  output logic                     rst_action_valid_o,
  output logic                     tx_bit_o,
  output logic                     tx_active_o
);

  logic                   code_valid;
  logic                   defbyte_valid;
  logic                   data_valid;

  i3c_ccc_pkg::ccc_byte_t resp_byte;
  logic                   resp_load;

  ccc_frame_ctrl u_frame_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rx_byte_i       (rx_byte_i),
    .rx_byte_valid_i (rx_byte_valid_i),
    .frame_start_i   (frame_start_i),
    .frame_stop_i    (frame_stop_i),
    .code_valid_o    (code_valid),
    .defbyte_valid_o (defbyte_valid),
    .data_valid_o    (data_valid)
  );

  ccc u_ccc (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .rx_byte_i          (rx_byte_i),
    .code_valid_i       (code_valid),
    .defbyte_valid_i    (defbyte_valid),
    .data_valid_i       (data_valid),
    .queue_size_i       (queue_size_i),
    .resp_byte_o        (resp_byte),
    .resp_load_o        (resp_load),
    .is_in_hdr_mode_o   (is_in_hdr_mode_o),
    .rst_action_o       (rst_action_o),
    .rst_action_valid_o (rst_action_valid_o)
  );

  // Bits leave MSB first as the bus asks for them
  ccc_resp_shifter u_resp_shifter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .resp_byte_i  (resp_byte),
    .resp_load_i  (resp_load),
    .tx_bit_req_i (tx_bit_req_i),
    .tx_bit_o     (tx_bit_o),
    .tx_active_o  (tx_active_o)
  );

endmodule

// ==== ccc_checker.sv ====
// CCC output assertions
`timescale 1ns/1ps

module ccc_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input i3c_ccc_pkg::ccc_byte_t rst_action_i,
  input logic                   rst_action_valid_i,
  input logic                   tx_bit_i,
  input logic                   tx_active_i
);

  // Quiet while reset is held
  reset_quiet: assert property (
    @(posedge clk_i) !rst_ni |-> (!tx_active_i && !rst_action_valid_i)
  ) else $error("tx_active or rst_action_valid high during reset");

  // Only the two supported reset actions are reported
  rst_action_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rst_action_valid_i |-> ((rst_action_i == i3c_ccc_pkg::RSTACT_NO_RESET) ||
                            (rst_action_i == i3c_ccc_pkg::RSTACT_PERIPHERAL_RESET))
  ) else $error("reset action 0x%0h is not a supported defining byte", rst_action_i);

  rst_action_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rst_action_valid_i |=> !rst_action_valid_i
  ) else $error("reset action strobe longer than one cycle");

  tx_bit_idle_low: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !tx_active_i |-> !tx_bit_i
  ) else $error("tx_bit high while the shifter is idle");

endmodule

bind ccc_top ccc_checker u_ccc_checker (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .rst_action_i       (rst_action_o),
  .rst_action_valid_i (rst_action_valid_o),
  .tx_bit_i           (tx_bit_o),
  .tx_active_i        (tx_active_o)
);

// ==== tb_ccc.sv ====
// CCC front end testbench
`timescale 1ns/1ps

module tb_ccc;

  logic                     clk;
  logic                     rst_n;
  i3c_ccc_pkg::ccc_byte_t   rx_byte;
  logic                     rx_valid;
  logic                     frame_start;
  logic                     frame_stop;
  i3c_ccc_pkg::queue_size_t queue_size;
  logic                     tx_bit_req;
  logic                     hdr_mode;
  i3c_ccc_pkg::ccc_byte_t   rst_action;
  logic                     rst_action_valid;
  logic                     tx_bit;
  logic                     tx_active;

  int unsigned value_errors;
  int unsigned timing_errors;
  int unsigned timeouts;
  logic [31:0] lfsr_q;

  // Reference model state
  i3c_ccc_pkg::frame_state_e m_state;
  i3c_ccc_pkg::ccc_byte_t    m_code;
  i3c_ccc_pkg::ccc_byte_t    m_shift;
  i3c_ccc_pkg::ccc_byte_t    m_rst_val;
  logic                      m_load_pend;
  logic                      m_rst_valid;
  int                        m_bits;
  logic                      m_accept;
  logic                      m_code_s;
  logic                      m_def_s;

  ccc_top DUT (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .rx_byte_i          (rx_byte),
    .rx_byte_valid_i    (rx_valid),
    .frame_start_i      (frame_start),
    .frame_stop_i       (frame_stop),
    .queue_size_i       (queue_size),
    .tx_bit_req_i       (tx_bit_req),
    .is_in_hdr_mode_o   (hdr_mode),
    .rst_action_o       (rst_action),
    .rst_action_valid_o (rst_action_valid),
    .tx_bit_o           (tx_bit),
    .tx_active_o        (tx_active)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic i3c_ccc_pkg::ccc_byte_t rand_byte();
    return i3c_ccc_pkg::ccc_byte_t'(rand_bits(8));
  endfunction

  function automatic logic is_rstact_code(input i3c_ccc_pkg::ccc_byte_t code);
    return (code == i3c_ccc_pkg::CCC_BCAST_RSTACT) || (code == i3c_ccc_pkg::CCC_DIRECT_RSTACT);
  endfunction

  function automatic logic is_getmxl_code(input i3c_ccc_pkg::ccc_byte_t code);
    return (code == i3c_ccc_pkg::CCC_DIRECT_GETMRL) || (code == i3c_ccc_pkg::CCC_DIRECT_GETMWL);
  endfunction

  // RX size in bits 23:16, TX size in bits 31:24
  function automatic i3c_ccc_pkg::ccc_byte_t expected_resp(input i3c_ccc_pkg::ccc_byte_t code,
                                                           input i3c_ccc_pkg::queue_size_t qs);
    if (code == i3c_ccc_pkg::CCC_DIRECT_GETMRL) begin
      return qs[23:16];
    end
    return qs[31:24];
  endfunction

  function automatic i3c_ccc_pkg::ccc_byte_t pick_code();
    case (rand_bits(3))
      32'd0:   return i3c_ccc_pkg::CCC_BCAST_ENTHDR0;
      32'd1:   return i3c_ccc_pkg::CCC_BCAST_RSTACT;
      32'd2:   return i3c_ccc_pkg::CCC_DIRECT_RSTACT;
      32'd3:   return i3c_ccc_pkg::CCC_DIRECT_GETMWL;
      32'd4:   return i3c_ccc_pkg::CCC_DIRECT_GETMRL;
      default: return rand_byte();
    endcase
  endfunction

  function automatic i3c_ccc_pkg::ccc_byte_t pick_defbyte();
    case (rand_bits(2))
      32'd0:   return i3c_ccc_pkg::RSTACT_NO_RESET;
      32'd1:   return i3c_ccc_pkg::RSTACT_PERIPHERAL_RESET;
      default: return rand_byte();
    endcase
  endfunction

  // Bytes that look meaningful but arrive outside a frame
  function automatic i3c_ccc_pkg::ccc_byte_t pick_stray();
    case (rand_bits(2))
      32'd0:   return i3c_ccc_pkg::RSTACT_NO_RESET;
      32'd1:   return i3c_ccc_pkg::CCC_BCAST_RSTACT;
      32'd2:   return i3c_ccc_pkg::CCC_DIRECT_GETMRL;
      default: return i3c_ccc_pkg::CCC_BCAST_ENTHDR0;
    endcase
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    value_errors++;
    $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  // Framing, decode and shifter rules, one step per clock
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_state     = i3c_ccc_pkg::ST_IDLE;
      m_code      = '0;
      m_shift     = '0;
      m_rst_val   = '0;
      m_load_pend = 1'b0;
      m_rst_valid = 1'b0;
      m_bits      = 0;
    end else begin
      m_accept = rx_valid && !frame_start && !frame_stop;
      m_code_s = m_accept && (m_state == i3c_ccc_pkg::ST_CODE);
      m_def_s  = m_accept && (m_state == i3c_ccc_pkg::ST_DEFBYTE);
      if (m_load_pend) begin
        m_shift = expected_resp(m_code, queue_size);
        m_bits  = 8;
      end else if (tx_bit_req && (m_bits != 0)) begin
        m_shift = {m_shift[6:0], 1'b0};
        m_bits--;
      end
      m_load_pend = m_code_s && is_getmxl_code(rx_byte);
      m_rst_valid = m_def_s && is_rstact_code(m_code) &&
                    ((rx_byte == i3c_ccc_pkg::RSTACT_NO_RESET) ||
                     (rx_byte == i3c_ccc_pkg::RSTACT_PERIPHERAL_RESET));
      m_rst_val   = rx_byte;
      if (m_code_s) begin
        m_code = rx_byte;
      end
      if (frame_stop) begin
        m_state = i3c_ccc_pkg::ST_IDLE;
      end else if (frame_start) begin
        m_state = i3c_ccc_pkg::ST_CODE;
      end else if (m_code_s) begin
        m_state = is_rstact_code(rx_byte) ? i3c_ccc_pkg::ST_DEFBYTE : i3c_ccc_pkg::ST_DATA;
      end else if (m_def_s) begin
        m_state = i3c_ccc_pkg::ST_DATA;
      end
    end
  end

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (hdr_mode !== (m_code == i3c_ccc_pkg::CCC_BCAST_ENTHDR0)) begin
        report_value("is_in_hdr_mode_o", 32'(hdr_mode),
                     32'(m_code == i3c_ccc_pkg::CCC_BCAST_ENTHDR0));
      end
      if (rst_action_valid !== m_rst_valid) begin
        report_value("rst_action_valid_o", 32'(rst_action_valid), 32'(m_rst_valid));
      end
      if (m_rst_valid && (rst_action !== m_rst_val)) begin
        report_value("rst_action_o", 32'(rst_action), 32'(m_rst_val));
      end
      if (tx_active !== (m_bits != 0)) begin
        report_value("tx_active_o", 32'(tx_active), 32'(m_bits != 0));
      end
      if (tx_bit !== ((m_bits != 0) && m_shift[7])) begin
        report_value("tx_bit_o", 32'(tx_bit), 32'((m_bits != 0) && m_shift[7]));
      end
    end
  end

  // Idle bus with stray bit requests
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      rx_valid    <= 1'b0;
      frame_start <= 1'b0;
      frame_stop  <= 1'b0;
      tx_bit_req  <= (rand_bits(2) == 0);
    end
  endtask

  task automatic send_byte(input i3c_ccc_pkg::ccc_byte_t b);
    @(posedge clk);
    rx_byte     <= b;
    rx_valid    <= 1'b1;
    frame_start <= 1'b0;
    frame_stop  <= 1'b0;
    tx_bit_req  <= 1'b0;
    @(posedge clk);
    rx_valid    <= 1'b0;
  endtask

  task automatic start_frame();
    @(posedge clk);
    queue_size  <= rand_bits(32);
    frame_start <= 1'b1;
    rx_valid    <= 1'b0;
    tx_bit_req  <= 1'b0;
    @(posedge clk);
    frame_start <= 1'b0;
  endtask

  // A byte sent with the stop must be dropped
  task automatic stop_frame(input logic with_byte, input i3c_ccc_pkg::ccc_byte_t b);
    @(posedge clk);
    frame_stop <= 1'b1;
    rx_valid   <= with_byte;
    rx_byte    <= b;
    tx_bit_req <= 1'b0;
    @(posedge clk);
    frame_stop <= 1'b0;
    rx_valid   <= 1'b0;
  endtask

  task automatic read_response(input i3c_ccc_pkg::ccc_byte_t exp_byte, input int nbits);
    i3c_ccc_pkg::ccc_byte_t got;
    i3c_ccc_pkg::ccc_byte_t exp_bits;
    int                     cnt;
    got      = '0;
    exp_bits = exp_byte >> (8 - nbits);
    for (int i = 0; i < nbits; i++) begin
      @(posedge clk);
      tx_bit_req <= 1'b1;
      @(negedge clk);
      if (!tx_active) begin
        timing_errors++;
        $display("** Error at %0t: tx_active_o = 0, expected 1 at response bit %0d", $time, i);
      end
      got = {got[6:0], tx_bit};
    end
    @(posedge clk);
    tx_bit_req <= 1'b0;
    if (got !== exp_bits) begin
      report_value("tx_bit_o", 32'(got), 32'(exp_bits));
    end
    if (nbits == 8) begin
      @(negedge clk);
      cnt = 1;
      while (tx_active && (cnt < 4)) begin
        @(negedge clk);
        cnt++;
      end
      if (tx_active) begin
        timeouts++;
        $display("Timeout at %0t: tx_active_o stayed high after eight bit requests", $time);
      end
    end
  endtask

  task automatic run_frame();
    i3c_ccc_pkg::ccc_byte_t code;
    i3c_ccc_pkg::ccc_byte_t resp;
    logic                   was_active;
    int                     cnt;
    int                     ndata;
    start_frame();
    code = pick_code();
    @(negedge clk);
    was_active = tx_active;
    send_byte(code);
    if (is_getmxl_code(code)) begin
      resp = expected_resp(code, queue_size);
      @(negedge clk);
      cnt = 1;
      while (!tx_active && (cnt < 16)) begin
        @(negedge clk);
        cnt++;
      end
      if (!tx_active) begin
        timeouts++;
        $display("Timeout at %0t: no response started after code 0x%0h", $time, code);
      end else begin
        if (!was_active && (cnt != 2)) begin
          timing_errors++;
          $display("** Error at %0t: tx_active_o rose %0d cycles after the code byte, expected 2",
                   $time, cnt);
        end
        // Short read, the next GETMxL frame cuts in
        if (rand_bits(2) == 0) begin
          read_response(resp, 3);
        end else begin
          read_response(resp, 8);
        end
      end
    end
    idle_cycles(int'(rand_bits(2)));
    send_byte(pick_defbyte());
    ndata = int'(rand_bits(2));
    for (int i = 0; i < ndata; i++) begin
      idle_cycles(int'(rand_bits(1)));
      send_byte(rand_byte());
    end
    stop_frame(rand_bits(2) == 0, pick_defbyte());
    if (rand_bits(2) == 0) begin
      send_byte(pick_stray());
    end
    idle_cycles(1 + int'(rand_bits(2)));
  endtask

  initial begin
    value_errors  = 0;
    timing_errors = 0;
    timeouts      = 0;
    lfsr_q        = 32'h9802;
    rst_n         = 1'b0;
    rx_byte       = '0;
    rx_valid      = 1'b0;
    frame_start   = 1'b0;
    frame_stop    = 1'b0;
    queue_size    = '0;
    tx_bit_req    = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycles(3);
    for (int f = 0; f < 200; f++) begin
      run_frame();
    end
    idle_cycles(4);
    $display("Errors: %0d value, %0d timing, %0d timeout", value_errors, timing_errors, timeouts);
    if ((value_errors + timing_errors + timeouts) == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
i3c_ccc_pkg.sv
ccc_frame_ctrl.sv
ccc.sv
ccc_resp_shifter.sv
ccc_top.sv
ccc_checker.sv
tb_ccc.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ccc -o tb_ccc

if ! ./obj_dir/tb_ccc > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
